// File: bench/id_stage_assertions.sv
// concurrent checks on the decode stage handshake, held execute outputs and redirect
`timescale 1ns/1ns
`default_nettype none

module id_stage_assertions #(
  parameter int XLEN = 64
) (
  input logic                           i_clk,
  input logic                           i_rst,
  input logic                           i_es_allowin,
  input logic                           i_ds_to_es_valid,
  input logic                           i_br_taken,
  input logic [XLEN-1:0]                i_es_pc,
  input logic [XLEN-1:0]                i_es_imm,
  input logic [id_pkg::ALU_OP_WD-1:0]   i_es_alu_op,
  input logic [id_pkg::REG_ADDR_WD-1:0] i_es_rd,
  input logic                           i_es_src2_imm,
  input logic                           i_es_gpr_wen,
  input logic                           i_es_is_load,
  input logic                           i_es_invalid
);

  // redirect only while the instruction leaves
  a_redirect_on_fire: assert property (@(posedge i_clk) disable iff (i_rst)
      i_br_taken |-> (i_ds_to_es_valid && i_es_allowin))
    else $error("redirect raised without a transfer to execute");

  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_ds_to_es_valid && !i_es_allowin) |=>
        ($stable(i_es_pc) && $stable(i_es_imm) && $stable(i_es_alu_op) &&
         $stable(i_es_rd) && $stable(i_es_src2_imm) && $stable(i_es_gpr_wen) &&
         $stable(i_es_is_load) && $stable(i_es_invalid)))
    else $error("execute outputs changed under back-pressure");

  a_empty_after_reset: assert property (@(posedge i_clk)
      $fell(i_rst) |-> !i_ds_to_es_valid)
    else $error("stage valid in the first cycle after reset");

endmodule

`default_nettype wire

// File: bench/tb_id_stage.sv
// decode stage testbench: clock, reset, random stimulus, reference model, checks, report
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;
  import id_pkg::*;

  localparam int XLEN           = 64;
  localparam int N_TESTS        = 5;
  localparam int XFERS_PER_TEST = 400;
  localparam int MAX_CYCLES     = N_TESTS * XFERS_PER_TEST * 10; // ten cycles per transfer

  logic                   clk = 1'b0;
  logic                   rst = 1'b1;
  logic                   fs_valid = 1'b0;
  logic [INST_WD-1:0]     fs_inst = NOP_INST;
  logic [XLEN-1:0]        fs_pc = '0;
  logic                   es_allowin = 1'b0;
  logic                   ws_gpr_wen = 1'b0;
  logic [REG_ADDR_WD-1:0] ws_gpr_waddr = '0;
  logic [XLEN-1:0]        ws_gpr_wdata = '0;
  logic [REG_ADDR_WD-1:0] es_byp_rd = '0;
  logic [XLEN-1:0]        es_byp_result = '0;
  logic                   es_byp_load = 1'b0;
  logic [REG_ADDR_WD-1:0] ms_byp_rd = '0;
  logic [XLEN-1:0]        ms_byp_result = '0;
  logic [REG_ADDR_WD-1:0] ws_byp_rd = '0;
  logic [XLEN-1:0]        ws_byp_result = '0;

  logic                   ds_allowin;
  logic                   ds_to_es_valid;
  logic [XLEN-1:0]        es_pc;
  logic [XLEN-1:0]        es_rs1_data;
  logic [XLEN-1:0]        es_rs2_data;
  logic [XLEN-1:0]        es_imm;
  logic [ALU_OP_WD-1:0]   es_alu_op;
  logic                   es_src2_imm;
  logic [REG_ADDR_WD-1:0] es_rd;
  logic                   es_gpr_wen;
  logic                   es_load;
  logic                   es_invalid;
  logic                   br_taken;
  logic [XLEN-1:0]        br_target;

  integer                 seed = 32'h6ee0;
  logic                   running = 1'b0;
  int unsigned            p_valid = 0;
  int unsigned            p_allowin = 0;
  int unsigned            p_load = 0;
  int unsigned            p_branch = 0;
  string                  cur_test = "reset";
  int unsigned            errors = 0;
  int unsigned            xfers = 0;
  int unsigned            cycles = 0;
  logic [XLEN-1:0]        shadow [32] = '{default: '0};
  logic [INST_WD-1:0]     q_inst [$];
  logic [XLEN-1:0]        q_pc [$];

  always #20 clk = ~clk;

  id_stage #(.XLEN(XLEN)) u_id_stage (
    .i_clk            (clk),
    .i_rst            (rst),
    .i_fs_valid       (fs_valid),
    .i_fs_inst        (fs_inst),
    .i_fs_pc          (fs_pc),
    .o_ds_allowin     (ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_es_pc          (es_pc),
    .o_es_rs1_data    (es_rs1_data),
    .o_es_rs2_data    (es_rs2_data),
    .o_es_imm         (es_imm),
    .o_es_alu_op      (es_alu_op),
    .o_es_src2_imm    (es_src2_imm),
    .o_es_rd          (es_rd),
    .o_es_gpr_wen     (es_gpr_wen),
    .o_es_load        (es_load),
    .o_es_invalid     (es_invalid),
    .o_br_taken       (br_taken),
    .o_br_target      (br_target),
    .i_ws_gpr_wen     (ws_gpr_wen),
    .i_ws_gpr_waddr   (ws_gpr_waddr),
    .i_ws_gpr_wdata   (ws_gpr_wdata),
    .i_es_byp_rd      (es_byp_rd),
    .i_es_byp_result  (es_byp_result),
    .i_es_load        (es_byp_load),
    .i_ms_byp_rd      (ms_byp_rd),
    .i_ms_byp_result  (ms_byp_result),
    .i_ws_byp_rd      (ws_byp_rd),
    .i_ws_byp_result  (ws_byp_result)
  );

  bind id_stage id_stage_assertions #(.XLEN(XLEN)) u_assert (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_es_allowin     (i_es_allowin),
    .i_ds_to_es_valid (o_ds_to_es_valid),
    .i_br_taken       (o_br_taken),
    .i_es_pc          (o_es_pc),
    .i_es_imm         (o_es_imm),
    .i_es_alu_op      (o_es_alu_op),
    .i_es_rd          (o_es_rd),
    .i_es_src2_imm    (o_es_src2_imm),
    .i_es_gpr_wen     (o_es_gpr_wen),
    .i_es_is_load     (o_es_load),
    .i_es_invalid     (o_es_invalid)
  );

  function automatic logic [31:0] rnd32();
    return $random(seed);
  endfunction

  function automatic int unsigned below(input int unsigned n);
    return rnd32() % n;
  endfunction

  function automatic logic chance(input int unsigned pct);
    return below(100) < pct;
  endfunction

  function automatic logic [REG_ADDR_WD-1:0] small_reg();
    return REG_ADDR_WD'(below(8)); // few registers, many hazards
  endfunction

  function automatic logic [INST_WD-1:0] gen_inst(input int unsigned p_br);
    logic [INST_WD-1:0] w;
    logic [6:0]         opc;
    logic [2:0]         f3;
    w = rnd32();
    if (below(100) < 4) begin
      opc = 7'(rnd32());
      while (opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_BRANCH, OPC_JAL}) begin
        opc = 7'(rnd32());
      end
    end else if (below(100) < p_br) begin
      opc = (below(4) == 0) ? OPC_JAL : OPC_BRANCH;
    end else begin
      case (below(3))
        0:       opc = OPC_OP;
        1:       opc = OPC_OP_IMM;
        default: opc = OPC_LOAD;
      endcase
    end
    w[6:0] = opc;
    if (opc != OPC_JAL) w[19:15] = small_reg();
    if (opc == OPC_OP || opc == OPC_BRANCH) w[24:20] = small_reg();
    if (opc != OPC_BRANCH) w[11:7] = small_reg();
    if (opc == OPC_OP) w[31:25] = (below(2) == 0) ? 7'h00 : 7'h20;
    f3 = 3'(below(6));
    if (opc == OPC_BRANCH) w[14:12] = (f3 < 3'd2) ? f3 : f3 + 3'd2; // skip 010, 011
    return w;
  endfunction

  // reference decode straight from the instruction formats
  task automatic decode_model(input logic [INST_WD-1:0] w,
                              output logic [REG_ADDR_WD-1:0] rs1,
                              output logic [REG_ADDR_WD-1:0] rs2,
                              output logic [REG_ADDR_WD-1:0] rd,
                              output logic [XLEN-1:0] imm,
                              output logic [ALU_OP_WD-1:0] alu,
                              output logic src2_imm,
                              output logic load,
                              output logic is_br,
                              output logic is_jal,
                              output logic invalid);
    logic alt;
    alt      = w[30];
    rs1      = w[19:15];
    rs2      = '0;
    rd       = w[11:7];
    imm      = {{(XLEN-12){w[31]}}, w[31:20]};
    alu      = ALU_ADD;
    src2_imm = 1'b0;
    load     = 1'b0;
    is_br    = 1'b0;
    is_jal   = 1'b0;
    invalid  = 1'b0;
    case (w[6:0])
      OPC_OP: begin
        rs2 = w[24:20];
        imm = '0;  // r-type has no immediate
      end
      OPC_OP_IMM: src2_imm = 1'b1;
      OPC_LOAD: begin
        src2_imm = 1'b1;
        load     = 1'b1;
      end
      OPC_BRANCH: begin
        rs2   = w[24:20];
        rd    = '0;
        imm   = {{(XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        is_br = 1'b1;
      end
      OPC_JAL: begin
        rs1    = '0;
        imm    = {{(XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        is_jal = 1'b1;
      end
      default: begin
        rs1     = '0;
        rd      = '0;
        invalid = 1'b1;
      end
    endcase
    if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) begin
      case (w[14:12])
        3'b000:  alu = (alt && w[6:0] == OPC_OP) ? ALU_SUB : ALU_ADD;
        3'b001:  alu = ALU_SLL;
        3'b010:  alu = ALU_SLT;
        3'b011:  alu = ALU_SLTU;
        3'b100:  alu = ALU_XOR;
        3'b101:  alu = alt ? ALU_SRA : ALU_SRL;
        3'b110:  alu = ALU_OR;
        default: alu = ALU_AND;
      endcase
    end
  endtask

  // youngest producer wins, x0 stays zero
  function automatic logic [XLEN-1:0] operand(input logic [REG_ADDR_WD-1:0] idx);
    if (idx == '0) return '0;
    if (es_byp_rd == idx) return es_byp_result;
    if (ms_byp_rd == idx) return ms_byp_result;
    if (ws_byp_rd == idx) return ws_byp_result;
    return shadow[idx];
  endfunction

  function automatic logic br_cond(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                   input logic [XLEN-1:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check(input string what, input logic [XLEN-1:0] exp,
                       input logic [XLEN-1:0] act);
    if (exp !== act) begin
      errors++;
      $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_cycle();
    logic [INST_WD-1:0]     inst;
    logic [XLEN-1:0]        pc;
    logic [REG_ADDR_WD-1:0] rs1;
    logic [REG_ADDR_WD-1:0] rs2;
    logic [REG_ADDR_WD-1:0] rd;
    logic [XLEN-1:0]        imm;
    logic [ALU_OP_WD-1:0]   alu;
    logic                   src2_imm;
    logic                   load;
    logic                   is_br;
    logic                   is_jal;
    logic                   invalid;
    logic                   exp_valid;
    logic                   exp_allowin;
    logic                   fire;
    logic                   taken;
    logic [XLEN-1:0]        d1;
    logic [XLEN-1:0]        d2;
    exp_valid = 1'b0;
    taken     = 1'b0;
    if (q_inst.size() != 0) begin
      inst = q_inst[0];
      pc   = q_pc[0];
      decode_model(inst, rs1, rs2, rd, imm, alu, src2_imm, load, is_br, is_jal, invalid);
      // load in execute still owes one of our sources
      exp_valid = !(es_byp_load && es_byp_rd != '0 && (es_byp_rd == rs1 || es_byp_rd == rs2));
    end
    fire        = exp_valid && es_allowin;
    exp_allowin = (q_inst.size() == 0) || fire;
    check("ds_to_es_valid", XLEN'(exp_valid), XLEN'(ds_to_es_valid));
    check("ds_allowin", XLEN'(exp_allowin), XLEN'(ds_allowin));
    if (exp_valid) begin
      d1 = operand(rs1);
      d2 = operand(rs2);
      check("es_pc", pc, es_pc);
      check("es_rs1_data", d1, es_rs1_data);
      check("es_rs2_data", d2, es_rs2_data);
      check("es_gpr_wen", XLEN'(rd != '0), XLEN'(es_gpr_wen));
      check("es_invalid", XLEN'(invalid), XLEN'(es_invalid));
      if (!invalid) check("es_imm", imm, es_imm);
      if (!is_br && !is_jal && !invalid) begin
        check("es_rd", XLEN'(rd), XLEN'(es_rd));
        check("es_alu_op", XLEN'(alu), XLEN'(es_alu_op));
        check("es_src2_imm", XLEN'(src2_imm), XLEN'(es_src2_imm));
        check("es_load", XLEN'(load), XLEN'(es_load));
      end
      taken = fire && (is_jal || (is_br && br_cond(inst[14:12], d1, d2)));
    end
    check("br_taken", XLEN'(taken), XLEN'(br_taken));
    if (taken) check("br_target", pc + imm, br_target);
    if (fire) begin
      void'(q_inst.pop_front());
      void'(q_pc.pop_front());
      xfers++;
    end
    if (fs_valid && exp_allowin && !taken) begin  // squashed slot never queued
      q_inst.push_back(fs_inst);
      q_pc.push_back(fs_pc);
    end
    if (ws_gpr_wen && ws_gpr_waddr != '0) shadow[ws_gpr_waddr] = ws_gpr_wdata;
  endtask

  always @(posedge clk) begin
    if (running) begin
      #1;
      fs_valid      = chance(p_valid);
      fs_inst       = gen_inst(p_branch);
      fs_pc         = {rnd32(), rnd32() & 32'hffff_fffc};
      es_allowin    = chance(p_allowin);
      es_byp_load   = chance(p_load);
      es_byp_rd     = small_reg();
      es_byp_result = {rnd32(), rnd32()};
      ms_byp_rd     = small_reg();
      ms_byp_result = {rnd32(), rnd32()};
      ws_byp_rd     = small_reg();
      ws_byp_result = {rnd32(), rnd32()};
      ws_gpr_wen    = chance(50);
      ws_gpr_waddr  = small_reg();
      ws_gpr_wdata  = {rnd32(), rnd32()};
    end
  end

  always @(negedge clk) begin
    if (!rst) check_cycle();
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: only %0d transfers after %0d cycles", xfers, cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic run_test(input string name, input int unsigned pv, input int unsigned pa,
                          input int unsigned pl, input int unsigned pb);
    int unsigned err0;
    int unsigned xfer0;
    cur_test  = name;
    p_valid   = pv;
    p_allowin = pa;
    p_load    = pl;
    p_branch  = pb;
    err0      = errors;
    xfer0     = xfers;
    while (xfers - xfer0 < XFERS_PER_TEST) @(posedge clk);
    $display("test %-16s done: %0d transfers, %0d errors", name, xfers - xfer0,
             errors - err0);
  endtask

  initial begin
    repeat (10) @(posedge clk);
    #1;
    rst     = 1'b0;
    running = 1'b1;
    run_test("decode_forward", 80, 100, 0, 10);
    run_test("load_use_stall", 80, 100, 60, 10);
    run_test("back_pressure", 90, 40, 20, 10);
    run_test("redirect", 90, 90, 10, 70);
    run_test("mixed", 60, 60, 30, 30);
    $display("%0d tests, %0d transfers, %0d cycles, %0d errors", N_TESTS, xfers, cycles,
             errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
// branch condition evaluation and redirect target for branches and jal
`timescale 1ns/1ns
`default_nettype none

module branch_unit #(
  parameter int XLEN = 64
) (
  input  logic            i_fire,
  input  logic            i_is_branch,
  input  logic            i_is_jal,
  input  logic [2:0]      i_br_func,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_imm,
  output logic            o_br_taken,
  output logic [XLEN-1:0] o_br_target
);
  import id_pkg::*;

  logic cond;

  always_comb begin
    case (i_br_func)
      F3_BEQ:  cond = (i_rs1_data == i_rs2_data);
      F3_BNE:  cond = (i_rs1_data != i_rs2_data);
      F3_BLT:  cond = ($signed(i_rs1_data) <  $signed(i_rs2_data));
      F3_BGE:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      F3_BLTU: cond = (i_rs1_data <  i_rs2_data);
      F3_BGEU: cond = (i_rs1_data >= i_rs2_data);
      default: cond = 1'b0;  // 010 / 011 never branch
    endcase
  end

  // same adder for branch and jal offsets
  assign o_br_target = i_pc + i_imm;

  // only in the cycle the instruction leaves for execute
  assign o_br_taken  = i_fire && (i_is_jal || (i_is_branch && cond));

endmodule

`default_nettype wire

// File: hdl/fwd_if.sv
// bypass bundle from execute, memory and write-back with forwarding and hazard modports
`timescale 1ns/1ns
`default_nettype none

interface fwd_if #(
  parameter int XLEN = 64
);
  import id_pkg::*;

  logic [REG_ADDR_WD-1:0] es_rd;
  logic [XLEN-1:0]        es_result;
  logic                   es_load;    // es result not ready yet
  logic [REG_ADDR_WD-1:0] ms_rd;
  logic [XLEN-1:0]        ms_result;
  logic [REG_ADDR_WD-1:0] ws_rd;
  logic [XLEN-1:0]        ws_result;

  modport fwd_sink (
    input es_rd, es_result, ms_rd, ms_result, ws_rd, ws_result
  );

  modport hazard_sink (
    input es_rd, es_load
  );

endinterface

`default_nettype wire

// File: hdl/gpr_file.sv
// general register file, 32 entries, two async read ports, one sync write port
`timescale 1ns/1ns
`default_nettype none

module gpr_file #(
  parameter int XLEN = 64
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_raddr1,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_raddr2,
  output logic [XLEN-1:0]                o_rdata1,
  output logic [XLEN-1:0]                o_rdata2,
  input  logic                           i_wen,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]                i_wdata
);
  import id_pkg::*;

  localparam int NREGS = 2 ** REG_ADDR_WD;

  logic [XLEN-1:0] regs [0:NREGS-1];

  // x0 is cleared here and never written after
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

endmodule

`default_nettype wire

// File: hdl/id_pipe_reg.sv
// decode stage valid bit, instruction and pc register, allowin, load-use stall, squash
`timescale 1ns/1ns
`default_nettype none

module id_pipe_reg #(
  parameter int XLEN = 64
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_fs_valid,
  input  logic [id_pkg::INST_WD-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]                i_fs_pc,
  input  logic                           i_es_allowin,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_rs1,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_rs2,
  input  logic                           i_br_taken,
  fwd_if.hazard_sink                     hz,
  output logic                           o_ds_allowin,
  output logic                           o_ds_to_es_valid,
  output logic                           o_fire,
  output id_pkg::inst_u                  o_inst,
  output logic [XLEN-1:0]                o_pc
);
  import id_pkg::*;

  logic ds_valid;
  logic load_stall;

  // load in execute whose rd we read, x0 excluded
  assign load_stall = hz.es_load && (hz.es_rd != '0) &&
                      ((hz.es_rd == i_rs1) || (hz.es_rd == i_rs2));

  assign o_ds_to_es_valid = ds_valid && !load_stall;
  assign o_fire           = o_ds_to_es_valid && i_es_allowin;
  assign o_ds_allowin     = !ds_valid || o_fire;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid && !i_br_taken;  // drop the slot behind a taken branch
    end
  end

  // nop keeps the decoded controls quiet while empty or squashed
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_inst <= NOP_INST;
    end else if (i_fs_valid && o_ds_allowin) begin
      o_inst <= i_br_taken ? NOP_INST : i_fs_inst;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      o_pc <= i_fs_pc;
    end
  end

endmodule

`default_nettype wire

// File: hdl/id_pkg.sv
// decode stage package: widths, opcodes, funct3 codes, alu op codes, instruction union
`default_nettype none

package id_pkg;

  localparam int INST_WD     = 32;
  localparam int REG_ADDR_WD = 5;
  localparam int ALU_OP_WD   = 4;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3, OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // srl / sra
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3, BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [ALU_OP_WD-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_WD-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_WD-1:0] ALU_AND  = 4'd2;
  localparam logic [ALU_OP_WD-1:0] ALU_OR   = 4'd3;
  localparam logic [ALU_OP_WD-1:0] ALU_XOR  = 4'd4;
  localparam logic [ALU_OP_WD-1:0] ALU_SLT  = 4'd5;
  localparam logic [ALU_OP_WD-1:0] ALU_SLTU = 4'd6;
  localparam logic [ALU_OP_WD-1:0] ALU_SLL  = 4'd7;
  localparam logic [ALU_OP_WD-1:0] ALU_SRL  = 4'd8;
  localparam logic [ALU_OP_WD-1:0] ALU_SRA  = 4'd9;

  localparam logic [INST_WD-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

  typedef union packed {
    struct packed {
      logic [6:0]             funct7;
      logic [REG_ADDR_WD-1:0] rs2;
      logic [REG_ADDR_WD-1:0] rs1;
      logic [2:0]             funct3;
      logic [REG_ADDR_WD-1:0] rd;
      logic [6:0]             opcode;
    } r;
    struct packed {
      logic [11:0]            imm12;
      logic [REG_ADDR_WD-1:0] rs1;
      logic [2:0]             funct3;
      logic [REG_ADDR_WD-1:0] rd;
      logic [6:0]             opcode;
    } i;
    struct packed {
      logic [6:0]             imm_hi; // inst[31:25]
      logic [REG_ADDR_WD-1:0] rs2;
      logic [REG_ADDR_WD-1:0] rs1;
      logic [2:0]             funct3;
      logic [4:0]             imm_lo; // inst[11:7]
      logic [6:0]             opcode;
    } b;
  } inst_u;

endpackage

`default_nettype wire

// File: hdl/id_stage.sv
// decode stage top: pipe register, decoder, register file, forwarding, branch unit
`timescale 1ns/1ns
`default_nettype none

module id_stage #(
  parameter int XLEN = 64
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  // fetch
  input  logic                           i_fs_valid,
  input  logic [id_pkg::INST_WD-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]                i_fs_pc,
  output logic                           o_ds_allowin,
  // execute
  input  logic                           i_es_allowin,
  output logic                           o_ds_to_es_valid,
  output logic [XLEN-1:0]                o_es_pc,
  output logic [XLEN-1:0]                o_es_rs1_data,
  output logic [XLEN-1:0]                o_es_rs2_data,
  output logic [XLEN-1:0]                o_es_imm,
  output logic [id_pkg::ALU_OP_WD-1:0]   o_es_alu_op,
  output logic                           o_es_src2_imm,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_es_rd,
  output logic                           o_es_gpr_wen,
  output logic                           o_es_load,
  output logic                           o_es_invalid,
  // redirect
  output logic                           o_br_taken,
  output logic [XLEN-1:0]                o_br_target,
  // write-back port
  input  logic                           i_ws_gpr_wen,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_ws_gpr_waddr,
  input  logic [XLEN-1:0]                i_ws_gpr_wdata,
  // bypass
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_es_byp_rd,
  input  logic [XLEN-1:0]                i_es_byp_result,
  input  logic                           i_es_load,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_ms_byp_rd,
  input  logic [XLEN-1:0]                i_ms_byp_result,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_ws_byp_rd,
  input  logic [XLEN-1:0]                i_ws_byp_result
);
  import id_pkg::*;

  inst_u                  ds_inst;
  logic                   fire;
  logic [REG_ADDR_WD-1:0] rs1;
  logic [REG_ADDR_WD-1:0] rs2;
  logic [XLEN-1:0]        rf_data1;
  logic [XLEN-1:0]        rf_data2;
  logic                   is_branch;
  logic                   is_jal;
  logic [2:0]             br_func;

  fwd_if #(.XLEN(XLEN)) u_fwd ();

  assign u_fwd.es_rd     = i_es_byp_rd;
  assign u_fwd.es_result = i_es_byp_result;
  assign u_fwd.es_load   = i_es_load;
  assign u_fwd.ms_rd     = i_ms_byp_rd;
  assign u_fwd.ms_result = i_ms_byp_result;
  assign u_fwd.ws_rd     = i_ws_byp_rd;
  assign u_fwd.ws_result = i_ws_byp_result;

  id_pipe_reg #(.XLEN(XLEN)) u_pipe (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_valid       (i_fs_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_br_taken       (o_br_taken),
    .hz               (u_fwd.hazard_sink),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_fire           (fire),
    .o_inst           (ds_inst),
    .o_pc             (o_es_pc)
  );

  inst_decoder #(.XLEN(XLEN)) u_dec (
    .i_inst      (ds_inst),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (o_es_rd),
    .o_imm       (o_es_imm),
    .o_alu_op    (o_es_alu_op),
    .o_src2_imm  (o_es_src2_imm),
    .o_gpr_wen   (o_es_gpr_wen),
    .o_load      (o_es_load),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_br_func   (br_func),
    .o_invalid   (o_es_invalid)
  );

  gpr_file #(.XLEN(XLEN)) u_gpr (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_data1),
    .o_rdata2 (rf_data2),
    .i_wen    (i_ws_gpr_wen),
    .i_waddr  (i_ws_gpr_waddr),
    .i_wdata  (i_ws_gpr_wdata)
  );

  operand_forward #(.XLEN(XLEN)) u_fwd_sel (
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rf_data1 (rf_data1),
    .i_rf_data2 (rf_data2),
    .fwd        (u_fwd.fwd_sink),
    .o_rs1_data (o_es_rs1_data),
    .o_rs2_data (o_es_rs2_data)
  );

  branch_unit #(.XLEN(XLEN)) u_bru (
    .i_fire      (fire),
    .i_is_branch (is_branch),
    .i_is_jal    (is_jal),
    .i_br_func   (br_func),
    .i_rs1_data  (o_es_rs1_data),
    .i_rs2_data  (o_es_rs2_data),
    .i_pc        (o_es_pc),
    .i_imm       (o_es_imm),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

`default_nettype wire

// File: hdl/inst_decoder.sv
// instruction decoder: register indices, sign-extended immediate, alu and control signals
`timescale 1ns/1ns
`default_nettype none

module inst_decoder #(
  parameter int XLEN = 64
) (
  input  id_pkg::inst_u                  i_inst,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rs1,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rs2,
  output logic [id_pkg::REG_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]                o_imm,
  output logic [id_pkg::ALU_OP_WD-1:0]   o_alu_op,
  output logic                           o_src2_imm,
  output logic                           o_gpr_wen,
  output logic                           o_load,
  output logic                           o_is_branch,
  output logic                           o_is_jal,
  output logic [2:0]                     o_br_func,
  output logic                           o_invalid
);
  import id_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic            writes_rd;

  // alt selects sub / sra, sub only exists for OP
  function automatic logic [ALU_OP_WD-1:0] alu_sel(input logic [2:0] f3, input logic alt,
                                                   input logic sub_ok);
    logic [ALU_OP_WD-1:0] op;
    case (f3)
      F3_ADD:  op = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign imm_i = {{(XLEN-12){i_inst.i.imm12[11]}}, i_inst.i.imm12};
  assign imm_b = {{(XLEN-13){i_inst.b.imm_hi[6]}}, i_inst.b.imm_hi[6], i_inst.b.imm_lo[0],
                  i_inst.b.imm_hi[5:0], i_inst.b.imm_lo[4:1], 1'b0};
  // jal offset is scattered over the rs1, funct3 and rs2 fields
  assign imm_j = {{(XLEN-21){i_inst.b.imm_hi[6]}}, i_inst.b.imm_hi[6], i_inst.b.rs1,
                  i_inst.b.funct3, i_inst.b.rs2[0], i_inst.b.imm_hi[5:0],
                  i_inst.b.rs2[4:1], 1'b0};

  always_comb begin
    o_rs1       = '0;  // unused sources stay x0, no false stalls
    o_rs2       = '0;
    o_rd        = '0;
    o_imm       = '0;
    o_alu_op    = ALU_ADD;
    o_src2_imm  = 1'b0;
    o_load      = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_br_func   = i_inst.b.funct3;
    o_invalid   = 1'b0;
    writes_rd   = 1'b0;
    case (i_inst.r.opcode)
      OPC_OP: begin
        o_rs1     = i_inst.r.rs1;
        o_rs2     = i_inst.r.rs2;
        o_rd      = i_inst.r.rd;
        o_alu_op  = alu_sel(i_inst.r.funct3, i_inst.r.funct7[5], 1'b1);
        writes_rd = 1'b1;
      end
      OPC_OP_IMM: begin
        o_rs1      = i_inst.i.rs1;
        o_rd       = i_inst.i.rd;
        o_imm      = imm_i;
        o_alu_op   = alu_sel(i_inst.i.funct3, i_inst.i.imm12[10], 1'b0);
        o_src2_imm = 1'b1;
        writes_rd  = 1'b1;
      end
      OPC_LOAD: begin
        o_rs1      = i_inst.i.rs1;
        o_rd       = i_inst.i.rd;
        o_imm      = imm_i;     // address = rs1 + imm
        o_src2_imm = 1'b1;
        o_load     = 1'b1;
        writes_rd  = 1'b1;
      end
      OPC_BRANCH: begin
        o_rs1       = i_inst.b.rs1;
        o_rs2       = i_inst.b.rs2;
        o_imm       = imm_b;
        o_is_branch = 1'b1;
      end
      OPC_JAL: begin
        o_rd      = i_inst.i.rd;  // link written by execute
        o_imm     = imm_j;
        o_is_jal  = 1'b1;
        writes_rd = 1'b1;
      end
      default: o_invalid = 1'b1;
    endcase
  end

  assign o_gpr_wen = writes_rd && (o_rd != '0) && !o_invalid;

endmodule

`default_nettype wire

// File: hdl/operand_forward.sv
// source operand select: execute, memory, write-back bypass, then register file
`timescale 1ns/1ns
`default_nettype none

module operand_forward #(
  parameter int XLEN = 64
) (
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_rs1,
  input  logic [id_pkg::REG_ADDR_WD-1:0] i_rs2,
  input  logic [XLEN-1:0]                i_rf_data1,
  input  logic [XLEN-1:0]                i_rf_data2,
  fwd_if.fwd_sink                        fwd,
  output logic [XLEN-1:0]                o_rs1_data,
  output logic [XLEN-1:0]                o_rs2_data
);
  import id_pkg::*;

  // rd of zero means the stage has nothing to offer
  function automatic logic hit(input logic [REG_ADDR_WD-1:0] idx,
                               input logic [REG_ADDR_WD-1:0] rd);
    return (rd != '0) && (rd == idx);
  endfunction

  always_comb begin
    if (hit(i_rs1, fwd.es_rd)) begin
      o_rs1_data = fwd.es_result;   // youngest first
    end else if (hit(i_rs1, fwd.ms_rd)) begin
      o_rs1_data = fwd.ms_result;
    end else if (hit(i_rs1, fwd.ws_rd)) begin
      o_rs1_data = fwd.ws_result;
    end else begin
      o_rs1_data = i_rf_data1;
    end
  end

  always_comb begin
    if (hit(i_rs2, fwd.es_rd)) begin
      o_rs2_data = fwd.es_result;
    end else if (hit(i_rs2, fwd.ms_rd)) begin
      o_rs2_data = fwd.ms_result;
    end else if (hit(i_rs2, fwd.ws_rd)) begin
      o_rs2_data = fwd.ws_result;
    end else begin
      o_rs2_data = i_rf_data2;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the decode stage testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sources.f --top-module tb_id_stage -Mdir obj_dir || exit 1

out="$(./obj_dir/Vtb_id_stage 2>&1)"
echo "$out"

echo "$out" | grep -qx "TEST RESULT: PASS" && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// File: sources.f
hdl/id_pkg.sv
hdl/fwd_if.sv
hdl/inst_decoder.sv
hdl/gpr_file.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/id_pipe_reg.sv
hdl/id_stage.sv
bench/id_stage_assertions.sv
bench/tb_id_stage.sv
